//--- hdl/cpu_pkg.sv
package cpu_pkg;

	// two-operand byte instructions are 10 ooo mmm
	localparam logic [1:0] OPC_TWO_OP = 2'b10;

	// reserved opcode loaded into inst at reset, it refetches the same address
	localparam logic [7:0] OPC_NOP = 8'h00;
	localparam logic [7:0] OPC_LD_XL_IMM = 8'h10;
	localparam logic [7:0] OPC_LDW_Y_IMM = 8'h21;
	localparam logic [7:0] OPC_LDW_Y_D = 8'h22;
	localparam logic [7:0] OPC_LDW_SP_Y = 8'h23;
	localparam logic [7:0] OPC_ST_IY_XL = 8'h30;
	localparam logic [7:0] OPC_JP_IMM = 8'h40;
	localparam logic [7:0] OPC_JP_Y = 8'h41;
	// the low three bits of a relative jump are its branch condition
	localparam logic [7:0] OPC_JR = 8'h50;
	localparam logic [7:0] OPC_JRZ = 8'h51;
	localparam logic [7:0] OPC_JRNZ = 8'h52;
	localparam logic [7:0] OPC_JRC = 8'h53;
	localparam logic [7:0] OPC_JRNC = 8'h54;
	localparam logic [7:0] OPC_JRN = 8'h55;
	localparam logic [7:0] OPC_JRNN = 8'h56;
	localparam logic [7:0] OPC_TRAP = 8'hff;

	localparam logic [2:0] OP2_ADD = 3'b000;
	localparam logic [2:0] OP2_ADC = 3'b001;
	localparam logic [2:0] OP2_SUB = 3'b010;
	localparam logic [2:0] OP2_SBC = 3'b011;
	localparam logic [2:0] OP2_CP = 3'b100;
	localparam logic [2:0] OP2_AND = 3'b101;
	localparam logic [2:0] OP2_OR = 3'b110;
	localparam logic [2:0] OP2_XOR = 3'b111;

	localparam logic [2:0] MODE_XH = 3'b000;
	localparam logic [2:0] MODE_YL = 3'b001;
	localparam logic [2:0] MODE_YH = 3'b010;
	localparam logic [2:0] MODE_ZL = 3'b011;
	localparam logic [2:0] MODE_IMM = 3'b100;
	localparam logic [2:0] MODE_DIR = 3'b101;
	localparam logic [2:0] MODE_ZREL = 3'b110;
	localparam logic [2:0] MODE_SPREL = 3'b111;

	localparam logic [2:0] COND_ALWAYS = 3'd0;
	localparam logic [2:0] COND_Z = 3'd1;
	localparam logic [2:0] COND_NZ = 3'd2;
	localparam logic [2:0] COND_C = 3'd3;
	localparam logic [2:0] COND_NC = 3'd4;
	localparam logic [2:0] COND_N = 3'd5;
	localparam logic [2:0] COND_NN = 3'd6;

	localparam logic [1:0] MEM_NONE = 2'd0;
	localparam logic [1:0] MEM_DIR = 2'd1;
	localparam logic [1:0] MEM_ZREL = 2'd2;
	localparam logic [1:0] MEM_SPREL = 2'd3;

	localparam logic [1:0] REG_X = 2'd0;
	localparam logic [1:0] REG_Y = 2'd1;
	localparam logic [1:0] REG_Z = 2'd2;
	localparam logic [1:0] REG_SP = 2'd3;

	localparam int FLAG_C = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 3;

	typedef enum logic [3:0] {ADD, ADC, SUB, SBC, AND, OR, XOR, PASS, SEX} alu_op_t;

	typedef struct packed {
		logic [1:0] length;
		alu_op_t alu_op;
		logic [2:0] src;
		logic is_two_op;
		logic writes_flags;
		logic writes_carry;
		logic discard_result;
		logic [1:0] wr_addr;
		logic [1:0] wr_be;
		logic is_store;
		logic is_jump_abs;
		logic is_jump_y;
		logic [2:0] cond;
		logic is_branch;
		logic [1:0] mem_mode;
		logic is_trap;
	} decoded_t;

endpackage

//--- hdl/regs_if.sv
`timescale 1ns/1ps

interface regs_if;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	logic [15:0] sp;
	logic [15:0] next_x;
	logic [15:0] next_y;
	logic [15:0] next_z;
	logic [15:0] next_sp;
	logic [1:0] wr_addr;
	logic [15:0] wr_data;
	logic [1:0] wr_en;

	modport store(output x, y, z, sp, next_x, next_y, next_z, next_sp,
		input wr_addr, wr_data, wr_en);
	modport reader(input x, y, z, sp, next_x, next_y, next_z, next_sp);
	modport writer(output wr_addr, wr_data, wr_en, input x, y);
endinterface

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset,
	regs_if.store regs
);

	// value of one register after the pending byte writes
	function automatic logic [15:0] merge(input logic [15:0] cur, input logic hit,
		input logic [1:0] en, input logic [15:0] data);
		logic [15:0] v;
		v = cur;
		if (hit && en[0])
			v[7:0] = data[7:0];
		if (hit && en[1])
			v[15:8] = data[15:8];
		return v;
	endfunction

	assign regs.next_x = merge(regs.x, regs.wr_addr == cpu_pkg::REG_X, regs.wr_en, regs.wr_data);
	assign regs.next_y = merge(regs.y, regs.wr_addr == cpu_pkg::REG_Y, regs.wr_en, regs.wr_data);
	assign regs.next_z = merge(regs.z, regs.wr_addr == cpu_pkg::REG_Z, regs.wr_en, regs.wr_data);
	assign regs.next_sp = merge(regs.sp, regs.wr_addr == cpu_pkg::REG_SP, regs.wr_en,
		regs.wr_data);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regs.x <= 16'h0000;
			regs.y <= 16'h0000;
			regs.z <= 16'h0000;
			regs.sp <= 16'h0000;
		end
		else
		begin
			regs.x <= regs.next_x;
			regs.y <= regs.next_y;
			regs.z <= regs.next_z;
			regs.sp <= regs.next_sp;
		end
	end

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
	input logic [7:0] opcode,
	output cpu_pkg::decoded_t dec
);

	always_comb
	begin
		dec = '0;
		dec.length = 2'd1;
		dec.alu_op = cpu_pkg::PASS;
		dec.src = cpu_pkg::MODE_IMM;
		if (opcode[7:6] == cpu_pkg::OPC_TWO_OP)
		begin
			dec.is_two_op = 1'b1;
			dec.writes_flags = 1'b1;
			dec.wr_addr = cpu_pkg::REG_X;
			dec.wr_be = 2'b01;
			dec.src = opcode[2:0];
			case (opcode[5:3])
				cpu_pkg::OP2_ADD: dec.alu_op = cpu_pkg::ADD;
				cpu_pkg::OP2_ADC: dec.alu_op = cpu_pkg::ADC;
				cpu_pkg::OP2_SUB: dec.alu_op = cpu_pkg::SUB;
				cpu_pkg::OP2_SBC: dec.alu_op = cpu_pkg::SBC;
				cpu_pkg::OP2_AND: dec.alu_op = cpu_pkg::AND;
				cpu_pkg::OP2_OR: dec.alu_op = cpu_pkg::OR;
				cpu_pkg::OP2_XOR: dec.alu_op = cpu_pkg::XOR;
				default:
				begin
					// cp is a subtract that only sets the flags
					dec.alu_op = cpu_pkg::SUB;
					dec.discard_result = 1'b1;
				end
			endcase
			dec.writes_carry = !opcode[5] || opcode[5:3] == cpu_pkg::OP2_CP;
			case (opcode[2:0])
				cpu_pkg::MODE_IMM: dec.length = 2'd2;
				cpu_pkg::MODE_DIR:
				begin
					dec.length = 2'd3;
					dec.mem_mode = cpu_pkg::MEM_DIR;
				end
				cpu_pkg::MODE_ZREL:
				begin
					dec.length = 2'd3;
					dec.mem_mode = cpu_pkg::MEM_ZREL;
				end
				cpu_pkg::MODE_SPREL:
				begin
					dec.length = 2'd2;
					dec.mem_mode = cpu_pkg::MEM_SPREL;
				end
				default: dec.length = 2'd1;
			endcase
		end
		else
		begin
			case (opcode)
				cpu_pkg::OPC_NOP: dec.length = 2'd0;
				cpu_pkg::OPC_LD_XL_IMM:
				begin
					dec.length = 2'd2;
					dec.wr_addr = cpu_pkg::REG_X;
					dec.wr_be = 2'b01;
				end
				cpu_pkg::OPC_LDW_Y_IMM:
				begin
					dec.length = 2'd3;
					dec.wr_addr = cpu_pkg::REG_Y;
					dec.wr_be = 2'b11;
				end
				cpu_pkg::OPC_LDW_Y_D:
				begin
					dec.length = 2'd2;
					dec.alu_op = cpu_pkg::SEX;
					dec.wr_addr = cpu_pkg::REG_Y;
					dec.wr_be = 2'b11;
				end
				cpu_pkg::OPC_LDW_SP_Y:
				begin
					// yl mode hands the whole of y to a pass
					dec.src = cpu_pkg::MODE_YL;
					dec.wr_addr = cpu_pkg::REG_SP;
					dec.wr_be = 2'b11;
				end
				cpu_pkg::OPC_ST_IY_XL: dec.is_store = 1'b1;
				cpu_pkg::OPC_JP_IMM:
				begin
					dec.length = 2'd3;
					dec.is_jump_abs = 1'b1;
				end
				cpu_pkg::OPC_JP_Y: dec.is_jump_y = 1'b1;
				cpu_pkg::OPC_JR, cpu_pkg::OPC_JRZ, cpu_pkg::OPC_JRNZ, cpu_pkg::OPC_JRC,
				cpu_pkg::OPC_JRNC, cpu_pkg::OPC_JRN, cpu_pkg::OPC_JRNN:
				begin
					dec.length = 2'd2;
					dec.is_branch = 1'b1;
					dec.cond = opcode[2:0];
				end
				cpu_pkg::OPC_TRAP: dec.is_trap = 1'b1;
				default: dec.length = 2'd1;
			endcase
		end
	end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_pkg::decoded_t dec,
	input logic [15:0] imm,
	input logic [7:0] mem_data,
	input logic carry_in,
	regs_if.reader regs,
	output logic [15:0] result,
	output logic c,
	output logic n,
	output logic z
);

	logic [15:0] src;
	logic [7:0] a;
	logic [8:0] sum;

	assign a = regs.x[7:0];

	// register modes with a low byte pass the full register for 16-bit loads
	always_comb
	begin
		case (dec.src)
			cpu_pkg::MODE_XH: src = {8'h00, regs.x[15:8]};
			cpu_pkg::MODE_YL: src = regs.y;
			cpu_pkg::MODE_YH: src = {8'h00, regs.y[15:8]};
			cpu_pkg::MODE_ZL: src = regs.z;
			cpu_pkg::MODE_IMM: src = imm;
			default: src = {8'h00, mem_data};
		endcase
	end

	// bit 8 is the carry for add and the borrow for subtract
	always_comb
	begin
		case (dec.alu_op)
			cpu_pkg::ADD: sum = {1'b0, a} + {1'b0, src[7:0]};
			cpu_pkg::ADC: sum = {1'b0, a} + {1'b0, src[7:0]} + {8'h00, carry_in};
			cpu_pkg::SUB: sum = {1'b0, a} - {1'b0, src[7:0]};
			cpu_pkg::SBC: sum = {1'b0, a} - {1'b0, src[7:0]} - {8'h00, carry_in};
			cpu_pkg::AND: sum = {1'b0, a & src[7:0]};
			cpu_pkg::OR: sum = {1'b0, a | src[7:0]};
			cpu_pkg::XOR: sum = {1'b0, a ^ src[7:0]};
			default: sum = {1'b0, src[7:0]};
		endcase
	end

	always_comb
	begin
		if (dec.is_two_op)
			result = {8'h00, sum[7:0]};
		else if (dec.alu_op == cpu_pkg::SEX)
			result = {{8{src[7]}}, src[7:0]};
		else
			result = src;
	end

	assign c = sum[8];
	assign n = result[7];
	assign z = result[7:0] == 8'h00;

endmodule

//--- hdl/addr_unit.sv
`timescale 1ns/1ps

module addr_unit #(
	parameter logic [15:0] RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input cpu_pkg::decoded_t dec,
	input logic [23:0] inst,
	input logic [7:0] flags,
	regs_if.reader regs,
	output logic [15:0] pc,
	output logic [15:0] next_pc,
	output logic [15:0] dread_addr
);

	logic taken;
	logic [15:0] disp;

	assign disp = {{8{inst[15]}}, inst[15:8]};

	always_comb
	begin
		case (dec.cond)
			cpu_pkg::COND_ALWAYS: taken = 1'b1;
			cpu_pkg::COND_Z: taken = flags[cpu_pkg::FLAG_Z];
			cpu_pkg::COND_NZ: taken = !flags[cpu_pkg::FLAG_Z];
			cpu_pkg::COND_C: taken = flags[cpu_pkg::FLAG_C];
			cpu_pkg::COND_NC: taken = !flags[cpu_pkg::FLAG_C];
			cpu_pkg::COND_N: taken = flags[cpu_pkg::FLAG_N];
			cpu_pkg::COND_NN: taken = !flags[cpu_pkg::FLAG_N];
			default: taken = 1'b0;
		endcase
	end

	// a taken relative jump counts from the jump itself, not from the next instruction
	always_comb
	begin
		if (dec.is_trap)
			next_pc = pc;
		else if (dec.is_jump_abs)
			next_pc = inst[23:8];
		else if (dec.is_jump_y)
			next_pc = regs.next_y;
		else if (dec.is_branch && taken)
			next_pc = pc + disp;
		else
			next_pc = pc + {14'h0000, dec.length};
	end

	always_comb
	begin
		case (dec.mem_mode)
			cpu_pkg::MEM_DIR: dread_addr = inst[23:8];
			cpu_pkg::MEM_ZREL: dread_addr = regs.z + inst[23:8];
			cpu_pkg::MEM_SPREL: dread_addr = regs.sp + {8'h00, inst[15:8]};
			default: dread_addr = 16'h0000;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else if (!stall)
			pc <= next_pc;
	end

endmodule

//--- hdl/retire_unit.sv
`timescale 1ns/1ps

module retire_unit (
	input logic clk,
	input logic reset,
	input logic stall,
	input cpu_pkg::decoded_t dec,
	input logic [15:0] result,
	input logic c,
	input logic n,
	input logic z,
	regs_if.writer regs,
	output logic [7:0] flags,
	output logic [15:0] dwrite_addr,
	output logic [15:0] dwrite_data,
	output logic dwrite_en,
	output logic trap
);

	logic commit;

	assign commit = !stall;

	assign regs.wr_addr = dec.wr_addr;
	assign regs.wr_data = result;
	assign regs.wr_en = (commit && !dec.discard_result) ? dec.wr_be : 2'b00;

	assign dwrite_en = commit && dec.is_store;
	assign dwrite_addr = regs.y;
	assign dwrite_data = {8'h00, regs.x[7:0]};

	// logic operations leave the carry alone
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= 8'h00;
		else if (commit && dec.writes_flags)
		begin
			flags[cpu_pkg::FLAG_N] <= n;
			flags[cpu_pkg::FLAG_Z] <= z;
			if (dec.writes_carry)
				flags[cpu_pkg::FLAG_C] <= c;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			trap <= 1'b0;
		else if (commit && dec.is_trap)
			trap <= 1'b1;
	end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter logic [15:0] RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic [15:0] iread_addr,
	input logic [23:0] iread_data,
	input logic ivalid,
	output logic [15:0] dread_addr,
	input logic [15:0] dread_data,
	output logic [15:0] dwrite_addr,
	output logic [15:0] dwrite_data,
	output logic dwrite_en,
	output logic trap
);

	regs_if regs ();

	cpu_pkg::decoded_t dec;
	logic [23:0] inst;
	logic stall;
	logic [15:0] next_pc;
	logic [15:0] result;
	logic c;
	logic n;
	logic z;
	logic [7:0] flags;

	// nothing commits without valid fetch data, and nothing at all after a trap
	assign stall = !ivalid || trap;
	assign iread_addr = next_pc;

	always_ff @(posedge clk)
	begin
		if (reset)
			inst <= {16'h0000, cpu_pkg::OPC_NOP};
		else if (!stall)
			inst <= iread_data;
	end

	regfile regfile0 (.clk(clk), .reset(reset), .regs(regs.store));

	decoder decoder0 (.opcode(inst[7:0]), .dec(dec));

	alu alu0 (.dec(dec), .imm(inst[23:8]), .mem_data(dread_data[7:0]),
		.carry_in(flags[cpu_pkg::FLAG_C]), .regs(regs.reader), .result(result),
		.c(c), .n(n), .z(z));

	addr_unit #(.RESET_PC(RESET_PC)) addr_unit0 (.clk(clk), .reset(reset), .stall(stall),
		.dec(dec), .inst(inst), .flags(flags), .regs(regs.reader), .pc(),
		.next_pc(next_pc), .dread_addr(dread_addr));

	retire_unit retire_unit0 (.clk(clk), .reset(reset), .stall(stall), .dec(dec),
		.result(result), .c(c), .n(n), .z(z), .regs(regs.writer), .flags(flags),
		.dwrite_addr(dwrite_addr), .dwrite_data(dwrite_data), .dwrite_en(dwrite_en),
		.trap(trap));

endmodule

//--- tb/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// linear congruential generator shared by program generation and ivalid gaps
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic int rnd(input int n);
	logic [31:0] v;
	v = lcg_next();
	return int'(v[30:8]) % n;
endfunction

function automatic logic [7:0] rnd8();
	return 8'(rnd(256));
endfunction

// instruction-set model, runs the whole program on its own copy of memory
task automatic run_model();
	logic [15:0] x, y, z, sp, pc, ea;
	logic fc, fn, fz, done, taken;
	logic [7:0] op, b1, b2, b;
	logic [8:0] s;
	int steps;
	x = 16'h0000;
	y = 16'h0000;
	z = 16'h0000;
	sp = 16'h0000;
	pc = RESET_PC;
	fc = 1'b0;
	fn = 1'b0;
	fz = 1'b0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000)
	begin
		op = mmem[pc];
		b1 = mmem[pc + 16'd1];
		b2 = mmem[pc + 16'd2];
		steps++;
		if (op[7:6] == 2'b10)
		begin
			case (op[2:0])
				3'd0: b = x[15:8];
				3'd1: b = y[7:0];
				3'd2: b = y[15:8];
				3'd3: b = z[7:0];
				3'd4: b = b1;
				default:
				begin
					if (op[2:0] == 3'd5)
						ea = {b2, b1};
					else if (op[2:0] == 3'd6)
						ea = z + {b2, b1};
					else
						ea = sp + {8'h00, b1};
					b = mmem[ea];
					exp_rd.push_back(ea);
				end
			endcase
			// subtract leaves the borrow in bit 8
			case (op[5:3])
				3'd0: s = {1'b0, x[7:0]} + {1'b0, b};
				3'd1: s = {1'b0, x[7:0]} + {1'b0, b} + {8'h00, fc};
				3'd2, 3'd4: s = {1'b0, x[7:0]} - {1'b0, b};
				3'd3: s = {1'b0, x[7:0]} - {1'b0, b} - {8'h00, fc};
				3'd5: s = {1'b0, x[7:0] & b};
				3'd6: s = {1'b0, x[7:0] | b};
				default: s = {1'b0, x[7:0] ^ b};
			endcase
			fn = s[7];
			fz = s[7:0] == 8'h00;
			if (op[5:3] <= 3'd4)
				fc = s[8];
			if (op[5:3] != 3'd4)
				x[7:0] = s[7:0];
			if (op[2:0] == 3'd4 || op[2:0] == 3'd7)
				pc = pc + 16'd2;
			else if (op[2:0] >= 3'd5)
				pc = pc + 16'd3;
			else
				pc = pc + 16'd1;
		end
		else if (op[7:4] == 4'h5 && op[3:0] < 4'd7)
		begin
			case (op[2:0])
				3'd0: taken = 1'b1;
				3'd1: taken = fz;
				3'd2: taken = !fz;
				3'd3: taken = fc;
				3'd4: taken = !fc;
				3'd5: taken = fn;
				default: taken = !fn;
			endcase
			pc = taken ? pc + {{8{b1[7]}}, b1} : pc + 16'd2;
		end
		else
		begin
			case (op)
				cpu_pkg::OPC_LD_XL_IMM:
				begin
					x[7:0] = b1;
					pc = pc + 16'd2;
				end
				cpu_pkg::OPC_LDW_Y_IMM:
				begin
					y = {b2, b1};
					pc = pc + 16'd3;
				end
				cpu_pkg::OPC_LDW_Y_D:
				begin
					y = {{8{b1[7]}}, b1};
					pc = pc + 16'd2;
				end
				cpu_pkg::OPC_LDW_SP_Y:
				begin
					sp = y;
					pc = pc + 16'd1;
				end
				cpu_pkg::OPC_ST_IY_XL:
				begin
					exp_st_addr.push_back(y);
					exp_st_data.push_back(x[7:0]);
					mmem[y] = x[7:0];
					pc = pc + 16'd1;
				end
				cpu_pkg::OPC_JP_IMM: pc = {b2, b1};
				cpu_pkg::OPC_JP_Y: pc = y;
				cpu_pkg::OPC_TRAP:
				begin
					done = 1'b1;
					model_trap_pc = pc;
				end
				default: pc = pc + 16'd1;
			endcase
		end
	end
endtask

`endif

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

	localparam logic [15:0] RESET_PC = 16'h4000;
	localparam int N_INSTR = 200;
	localparam int PERIOD = 8;

	logic clk = 1'b0;
	logic reset;
	logic ivalid;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic dwrite_en;
	logic trap;

	logic [31:0] lcg_state = 32'h9633b102;
	logic [7:0] mem [65536];
	logic [7:0] mmem [65536];
	logic [15:0] exp_st_addr [$];
	logic [7:0] exp_st_data [$];
	logic [15:0] exp_rd [$];
	logic [15:0] model_trap_pc;
	logic [15:0] prefix_end;
	logic [7:0] g_op [256];
	logic [7:0] g_b1 [256];
	logic [7:0] g_b2 [256];
	logic [15:0] g_addr [256];
	int g_len [256];
	int g_tgt [256];
	int unit_first [256];
	int ni;
	int nu;
	int store_total;
	int err_reset = 0;
	int err_store = 0;
	int err_alu = 0;
	int err_addr = 0;
	int err_stall = 0;
	int err_trap = 0;
	logic after_reset = 1'b1;
	logic running = 1'b0;
	logic [15:0] exec_pc = 16'h0000;

	`include "tb_model.svh"

	always #(PERIOD / 2) clk = !clk;

	cpu_core #(.RESET_PC(RESET_PC)) dut0 (.clk(clk), .reset(reset), .iread_addr(iread_addr),
		.iread_data(iread_data), .ivalid(ivalid), .dread_addr(dread_addr),
		.dread_data(dread_data), .dwrite_addr(dwrite_addr), .dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en), .trap(trap));

	assign iread_data = {mem[iread_addr + 16'd2], mem[iread_addr + 16'd1], mem[iread_addr]};
	assign dread_data = {mem[dread_addr + 16'd1], mem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite_en)
			mem[dwrite_addr] <= dwrite_data[7:0];
	end

	// the instruction in execution sits at the fetch address of the last commit
	always @(posedge clk)
	begin
		if (reset)
			running <= 1'b0;
		else if (ivalid && !trap)
		begin
			exec_pc <= iread_addr;
			running <= 1'b1;
		end
	end

	function automatic int two_op_len(input logic [2:0] mode);
		if (mode == 3'd4 || mode == 3'd7)
			return 2;
		else if (mode >= 3'd5)
			return 3;
		return 1;
	endfunction

	task automatic add_instr(input logic [7:0] op, input logic [7:0] b1, input logic [7:0] b2,
		input int len, input int tgt);
		g_op[ni] = op;
		g_b1[ni] = b1;
		g_b2[ni] = b2;
		g_len[ni] = len;
		g_tgt[ni] = tgt;
		ni++;
	endtask

	task automatic new_unit();
		unit_first[nu] = ni;
		nu++;
	endtask

	// stores always go through y into the data region at 8000..8fff
	task automatic add_store();
		new_unit();
		add_instr(cpu_pkg::OPC_LDW_Y_IMM, rnd8(), 8'h80 + 8'(rnd(16)), 3, -1);
		add_instr(cpu_pkg::OPC_ST_IY_XL, 8'h00, 8'h00, 1, -1);
	endtask

	task automatic build_program();
		int k, i, t, np;
		logic [2:0] m;
		logic [15:0] a;
		ni = 0;
		nu = 0;
		// one pass over every operation, each with its own addressing mode and branch
		for (k = 0; k < 8; k++)
		begin
			new_unit();
			add_instr(cpu_pkg::OPC_LD_XL_IMM, rnd8(), 8'h00, 2, -1);
			new_unit();
			add_instr({cpu_pkg::OPC_TWO_OP, k[2:0], k[2:0]}, rnd8(), rnd8(),
				two_op_len(k[2:0]), -1);
			add_store();
			new_unit();
			add_instr(cpu_pkg::OPC_JR + 8'(k % 7), 8'h00, 8'h00, 2, nu + 1);
			add_store();
		end
		np = ni;
		while (ni < N_INSTR - 2)
		begin
			case (rnd(8))
				0, 1:
				begin
					new_unit();
					m = 3'(rnd(8));
					add_instr({cpu_pkg::OPC_TWO_OP, 3'(rnd(8)), m}, rnd8(), rnd8(),
						two_op_len(m), -1);
				end
				2:
				begin
					new_unit();
					add_instr(cpu_pkg::OPC_LD_XL_IMM, rnd8(), 8'h00, 2, -1);
				end
				3:
				begin
					new_unit();
					case (rnd(3))
						0: add_instr(cpu_pkg::OPC_LDW_Y_IMM, rnd8(), rnd8(), 3, -1);
						1: add_instr(cpu_pkg::OPC_LDW_Y_D, rnd8(), 8'h00, 2, -1);
						default: add_instr(cpu_pkg::OPC_LDW_SP_Y, 8'h00, 8'h00, 1, -1);
					endcase
				end
				4, 5: add_store();
				6:
				begin
					new_unit();
					add_instr(cpu_pkg::OPC_JR + 8'(rnd(7)), 8'h00, 8'h00, 2, nu + rnd(3));
				end
				default:
				begin
					new_unit();
					if (rnd(2) == 0)
						add_instr(cpu_pkg::OPC_JP_IMM, 8'h00, 8'h00, 3, nu + rnd(3));
					else
					begin
						add_instr(cpu_pkg::OPC_LDW_Y_IMM, 8'h00, 8'h00, 3, nu + rnd(3));
						add_instr(cpu_pkg::OPC_JP_Y, 8'h00, 8'h00, 1, -1);
					end
				end
			endcase
		end
		new_unit();
		add_instr(cpu_pkg::OPC_TRAP, 8'h00, 8'h00, 1, -1);
		a = RESET_PC;
		for (i = 0; i < ni; i++)
		begin
			g_addr[i] = a;
			a = a + 16'(g_len[i]);
		end
		prefix_end = g_addr[np];
		// jump targets are unit starts, resolved once the layout is known
		for (i = 0; i < ni; i++)
		begin
			if (g_tgt[i] >= 0)
			begin
				t = g_tgt[i] < nu ? g_tgt[i] : nu - 1;
				a = g_addr[unit_first[t]];
				if (g_op[i][7:4] == 4'h5)
					g_b1[i] = 8'(a - g_addr[i]);
				else
					{g_b2[i], g_b1[i]} = a;
			end
			mem[g_addr[i]] = g_op[i];
			if (g_len[i] > 1)
				mem[g_addr[i] + 16'd1] = g_b1[i];
			if (g_len[i] > 2)
				mem[g_addr[i] + 16'd2] = g_b2[i];
		end
	endtask

	task automatic report(input string name, input int errs);
		if (errs == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d error(s)", name, errs);
	endtask

	always @(negedge clk)
	begin
		if (reset || after_reset)
		begin
			if (dwrite_en || trap || iread_addr != RESET_PC)
			begin
				$display("[ERROR] reset: expected en 0 trap 0 fetch %h, actual en %b trap %b fetch %h",
					RESET_PC, dwrite_en, trap, iread_addr);
				err_reset++;
			end
			if (!reset)
				after_reset = 1'b0;
		end
		else
		begin
			if (dwrite_en && !ivalid)
			begin
				$display("store issued at %h while ivalid was low", dwrite_addr);
				err_stall++;
			end
			else if (dwrite_en && exp_st_addr.size() == 0)
			begin
				$display("store to %h beyond the expected store list", dwrite_addr);
				err_store++;
			end
			else if (dwrite_en)
			begin
				if (dwrite_addr != exp_st_addr[0] || dwrite_data[7:0] != exp_st_data[0])
				begin
					// stores of the directed prefix show each alu operation and branch
					if (exec_pc < prefix_end)
					begin
						$display("[ERROR] alu and flags: expected %h <- %h, actual %h <- %h",
							exp_st_addr[0], exp_st_data[0], dwrite_addr, dwrite_data[7:0]);
						err_alu++;
					end
					else
					begin
						$display("[ERROR] stores: expected %h <- %h, actual %h <- %h",
							exp_st_addr[0], exp_st_data[0], dwrite_addr, dwrite_data[7:0]);
						err_store++;
					end
				end
				void'(exp_st_addr.pop_front());
				void'(exp_st_data.pop_front());
			end
			if (running && ivalid && !trap && mem[exec_pc][7:6] == 2'b10
				&& mem[exec_pc][2:0] >= 3'd5)
			begin
				if (exp_rd.size() == 0)
				begin
					$display("memory operand read at %h beyond the expected list", exec_pc);
					err_addr++;
				end
				else
				begin
					if (dread_addr != exp_rd[0])
					begin
						$display("[ERROR] addressing: expected %h, actual %h",
							exp_rd[0], dread_addr);
						err_addr++;
					end
					void'(exp_rd.pop_front());
				end
			end
		end
	end

	initial
	begin
		#((4 * N_INSTR + 4 + 20) * PERIOD);
		$display("trap never reached");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int i;
		int total;
		int failed;
		reset = 1'b1;
		ivalid = 1'b1;
		for (i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
		build_program();
		for (i = 0; i < 65536; i++)
			mmem[i] = mem[i];
		run_model();
		store_total = exp_st_addr.size();
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		while (!trap)
		begin
			@(posedge clk);
			#1 ivalid = rnd(4) != 0;
		end
		if (iread_addr != model_trap_pc)
		begin
			$display("[ERROR] trap: expected fetch %h, actual %h", model_trap_pc, iread_addr);
			err_trap++;
		end
		if (exp_st_addr.size() != 0)
		begin
			$display("[ERROR] stores: expected count %0d, actual %0d", store_total,
				store_total - exp_st_addr.size());
			err_store++;
		end
		if (exp_rd.size() != 0)
		begin
			$display("%0d memory operand reads never happened", exp_rd.size());
			err_addr++;
		end
		repeat (10)
		begin
			@(posedge clk);
			#1 ivalid = rnd(4) != 0;
			if (!trap || iread_addr != model_trap_pc)
			begin
				$display("[ERROR] trap hold: expected trap 1 fetch %h, actual trap %b fetch %h",
					model_trap_pc, trap, iread_addr);
				err_trap++;
			end
		end
		report("reset", err_reset);
		report("stores", err_store);
		report("alu and flags", err_alu);
		report("addressing", err_addr);
		report("stall", err_stall);
		report("trap", err_trap);
		total = err_reset + err_store + err_alu + err_addr + err_stall + err_trap;
		failed = (err_reset != 0) + (err_store != 0) + (err_alu != 0) + (err_addr != 0)
			+ (err_stall != 0) + (err_trap != 0);
		$display("tests: 6, failed: %0d, errors: %0d, stores: %0d", failed, total, store_total);
		if (total == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- files.f
+incdir+tb
hdl/cpu_pkg.sv
hdl/regs_if.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/alu.sv
hdl/addr_unit.sv
hdl/retire_unit.sv
hdl/cpu_core.sv
tb/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_cpu -o tb_cpu_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1
